//--- rtl/dcache_pkg.sv
// cache geometry constants, address field types, memory command kind and shared structs
package dcache_pkg;

    parameter int WORD_W   = 64;
    parameter int STRB_W   = 8;
    parameter int INDEX_W  = 6;
    parameter int OFFSET_W = 3;
    parameter int TAG_W    = 55;
    parameter int AGE_W    = 3;

    typedef logic [63:0]         addr_t;
    typedef logic [WORD_W-1:0]   word_t;
    typedef logic [STRB_W-1:0]   strb_t;
    typedef logic [INDEX_W-1:0]  index_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic                way_t;

    typedef enum logic {
        MEM_WRITEBACK = 1'b0,
        MEM_REFILL    = 1'b1
    } mem_kind_e;

    // one write into the arrays, tag and set_valid only matter on refill
    typedef struct packed {
        logic   en;
        way_t   way;
        index_t index;
        strb_t  strb;
        word_t  data;
        tag_t   tag;
        logic   set_valid;
    } way_write_t;

    // lookup result of one way
    typedef struct packed {
        logic  valid;
        tag_t  tag;
        word_t data;
    } way_line_t;

    // addr is word aligned, data only used by write-backs
    typedef struct packed {
        mem_kind_e kind;
        addr_t     addr;
        word_t     data;
    } mem_cmd_t;

endpackage

//--- rtl/dcache_ways.sv
// two-way tag, valid and data arrays with registered read and byte-strobe write
`timescale 1ns/100ps

module dcache_ways
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic       clk,
    input  logic       rst_i,
    input  index_t     rd_index_i,
    input  way_write_t wr_i,
    output way_line_t  line0_o,
    output way_line_t  line1_o
);

    word_t               data_mem  [2][NUM_SETS];
    tag_t                tag_mem   [2][NUM_SETS];
    logic [NUM_SETS-1:0] valid_q   [2];
    way_line_t           line_q    [2];

    for (genvar w = 0; w < 2; w++) begin : g_way
        logic wr_hit;

        assign wr_hit = wr_i.en && (wr_i.way == way_t'(w));

        // valid bits are the only state cleared by reset
        always_ff @(posedge clk) begin
            if (rst_i) begin
                valid_q[w] <= '0;
            end else if (wr_hit && wr_i.set_valid) begin
                valid_q[w][wr_i.index] <= 1'b1;
            end
        end

        // byte lanes
        always_ff @(posedge clk) begin
            if (wr_hit) begin
                for (int b = 0; b < STRB_W; b++) begin
                    if (wr_i.strb[b]) begin
                        data_mem[w][wr_i.index][b*8 +: 8] <= wr_i.data[b*8 +: 8];
                    end
                end
            end
        end

        // tag only changes together with a refill
        always_ff @(posedge clk) begin
            if (wr_hit && wr_i.set_valid) begin
                tag_mem[w][wr_i.index] <= wr_i.tag;
            end
        end

        // read sees the array before a same-cycle write
        always_ff @(posedge clk) begin
            line_q[w].valid <= valid_q[w][rd_index_i];
            line_q[w].tag   <= tag_mem[w][rd_index_i];
            line_q[w].data  <= data_mem[w][rd_index_i];
        end
    end

    assign line0_o = line_q[0];
    assign line1_o = line_q[1];

endmodule

//--- rtl/dcache_ctrl.sv
// request FSM with hit detection, age counters, dirty bits, victim choice and memory commands
`timescale 1ns/100ps

module dcache_ctrl
    import dcache_pkg::*;
(
    input  logic       clk,
    input  logic       rst_i,
    input  logic       rd_valid_i,
    input  logic       wr_valid_i,
    input  addr_t      addr_i,
    input  word_t      wdata_i,
    input  strb_t      strb_i,
    input  way_line_t  line0_i,
    input  way_line_t  line1_i,
    input  logic       cmd_done_i,
    input  word_t      fill_data_i,
    output logic       done_o,
    output word_t      rdata_o,
    output index_t     rd_index_o,
    output way_write_t way_wr_o,
    output mem_cmd_t   cmd_o,
    output logic       cmd_start_o
);

    localparam int SETS = 2 ** INDEX_W;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        COMPARE,
        WRITEBACK,
        REFILL
    } ctrl_state_e;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    logic [1:0]       dirty_q [SETS];
    logic [AGE_W-1:0] age_q   [SETS][2];

    tag_t      req_tag;
    index_t    req_index;
    logic      hit0;
    logic      hit1;
    logic      hit;
    way_t      hit_way;
    way_t      victim_way;
    way_line_t victim_line;
    logic      victim_dirty;
    way_t      victim_q;
    mem_cmd_t  cmd_q;
    logic      cmd_start_q;
    mem_cmd_t  refill_cmd;
    mem_cmd_t  wb_cmd;

    function automatic logic [AGE_W-1:0] age_inc(input logic [AGE_W-1:0] age);
        return (age == '1) ? age : age + 1'b1;
    endfunction

    assign req_tag    = addr_i[OFFSET_W+INDEX_W +: TAG_W];
    assign req_index  = addr_i[OFFSET_W +: INDEX_W];
    assign rd_index_o = req_index;

    assign hit0    = line0_i.valid && (line0_i.tag == req_tag);
    assign hit1    = line1_i.valid && (line1_i.tag == req_tag);
    assign hit     = hit0 || hit1;
    assign hit_way = hit0 ? 1'b0 : 1'b1;

    // first invalid way, else the older one, tie to way 0
    assign victim_way = !line0_i.valid ? 1'b0 :
                        !line1_i.valid ? 1'b1 :
                        (age_q[req_index][1] > age_q[req_index][0]);
    assign victim_line  = victim_way ? line1_i : line0_i;
    assign victim_dirty = victim_line.valid && dirty_q[req_index][victim_way];

    assign refill_cmd.kind = MEM_REFILL;
    assign refill_cmd.addr = {req_tag, req_index, OFFSET_W'(0)};
    assign refill_cmd.data = '0;

    assign wb_cmd.kind = MEM_WRITEBACK;
    assign wb_cmd.addr = {victim_line.tag, req_index, OFFSET_W'(0)};
    assign wb_cmd.data = victim_line.data;

    assign done_o      = (state_q == COMPARE) && hit;
    assign rdata_o     = hit_way ? line1_i.data : line0_i.data;
    assign cmd_o       = cmd_q;
    assign cmd_start_o = cmd_start_q;

    always_comb begin
        state_d = state_q;
        case (state_q)
            IDLE: begin
                if (rd_valid_i || wr_valid_i) begin
                    state_d = LOOKUP;
                end
            end
            LOOKUP: state_d = COMPARE;
            COMPARE: begin
                if (hit) begin
                    state_d = IDLE;
                end else if (victim_dirty) begin
                    state_d = WRITEBACK;
                end else begin
                    state_d = REFILL;
                end
            end
            WRITEBACK: begin
                if (cmd_done_i) begin
                    state_d = REFILL;
                end
            end
            REFILL: begin
                // replay the lookup, which then hits
                if (cmd_done_i) begin
                    state_d = LOOKUP;
                end
            end
            default: state_d = IDLE;
        endcase
    end

    always_comb begin
        way_wr_o = '0;
        if (state_q == COMPARE && hit && wr_valid_i) begin
            way_wr_o.en    = 1'b1;
            way_wr_o.way   = hit_way;
            way_wr_o.index = req_index;
            way_wr_o.strb  = strb_i;
            way_wr_o.data  = wdata_i;
        end else if (state_q == REFILL && cmd_done_i) begin
            way_wr_o.en        = 1'b1;
            way_wr_o.way       = victim_q;
            way_wr_o.index     = req_index;
            way_wr_o.strb      = '1;
            way_wr_o.data      = fill_data_i;
            way_wr_o.tag       = req_tag;
            way_wr_o.set_valid = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q     <= IDLE;
            cmd_start_q <= 1'b0;
        end else begin
            state_q     <= state_d;
            cmd_start_q <= (state_q == COMPARE && !hit) ||
                           (state_q == WRITEBACK && cmd_done_i);
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == COMPARE && !hit) begin
            victim_q <= victim_way;
            cmd_q    <= victim_dirty ? wb_cmd : refill_cmd;
        end else if (state_q == WRITEBACK && cmd_done_i) begin
            cmd_q <= refill_cmd;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int s = 0; s < SETS; s++) begin
                dirty_q[s]  <= '0;
                age_q[s][0] <= '0;
                age_q[s][1] <= '0;
            end
        end else begin
            if (state_q == COMPARE && hit) begin
                age_q[req_index][hit_way]  <= '0;
                age_q[req_index][!hit_way] <= age_inc(age_q[req_index][!hit_way]);
                if (wr_valid_i) begin
                    dirty_q[req_index][hit_way] <= 1'b1;
                end
            end
            if (state_q == WRITEBACK && cmd_done_i) begin
                dirty_q[req_index][victim_q] <= 1'b0;
            end
            if (state_q == REFILL && cmd_done_i) begin
                age_q[req_index][victim_q] <= '0;
            end
        end
    end

endmodule

//--- rtl/dcache_mem_port.sv
// memory command holding register with ready handshake and refill data capture
`timescale 1ns/100ps

module dcache_mem_port
    import dcache_pkg::*;
(
    input  logic     clk,
    input  logic     rst_i,
    input  mem_cmd_t cmd_i,
    input  logic     cmd_start_i,
    input  logic     mem_ready_i,
    input  word_t    mem_rdata_i,
    output mem_cmd_t mem_req_o,
    output logic     mem_valid_o,
    output logic     cmd_done_o,
    output word_t    fill_data_o
);

    mem_cmd_t cmd_q;
    logic     valid_q;
    logic     done_q;
    word_t    fill_q;
    logic     accept;

    // the ready cycle ends the command
    assign accept = valid_q && mem_ready_i;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            valid_q <= 1'b0;
            done_q  <= 1'b0;
        end else begin
            done_q <= accept;
            if (cmd_start_i) begin
                valid_q <= 1'b1;
            end else if (accept) begin
                valid_q <= 1'b0;
            end
        end
    end

    // command held stable while mem_valid_o is up
    always_ff @(posedge clk) begin
        if (cmd_start_i) begin
            cmd_q <= cmd_i;
        end
    end

    // refill word kept for the controller's done cycle
    always_ff @(posedge clk) begin
        if (accept && cmd_q.kind == MEM_REFILL) begin
            fill_q <= mem_rdata_i;
        end
    end

    assign mem_req_o   = cmd_q;
    assign mem_valid_o = valid_q;
    assign cmd_done_o  = done_q;
    assign fill_data_o = fill_q;

endmodule

//--- rtl/dcache_top.sv
// data cache top level with controller, way arrays and memory port
`timescale 1ns/100ps

module dcache_top
    import dcache_pkg::*;
#(
    parameter int NUM_SETS = 64
) (
    input  logic     clk,
    input  logic     rst_i,
    input  logic     rd_valid_i,
    input  logic     wr_valid_i,
    input  addr_t    addr_i,
    input  word_t    wdata_i,
    input  strb_t    strb_i,
    input  logic     mem_ready_i,
    input  word_t    mem_rdata_i,
    output logic     done_o,
    output word_t    rdata_o,
    output mem_cmd_t mem_req_o,
    output logic     mem_valid_o
);

    index_t     rd_index;
    way_write_t way_wr;
    way_line_t  line0;
    way_line_t  line1;
    mem_cmd_t   cmd;
    logic       cmd_start;
    logic       cmd_done;
    word_t      fill_data;

    dcache_ctrl u_ctrl (
        .clk         (clk),
        .rst_i       (rst_i),
        .rd_valid_i  (rd_valid_i),
        .wr_valid_i  (wr_valid_i),
        .addr_i      (addr_i),
        .wdata_i     (wdata_i),
        .strb_i      (strb_i),
        .line0_i     (line0),
        .line1_i     (line1),
        .cmd_done_i  (cmd_done),
        .fill_data_i (fill_data),
        .done_o      (done_o),
        .rdata_o     (rdata_o),
        .rd_index_o  (rd_index),
        .way_wr_o    (way_wr),
        .cmd_o       (cmd),
        .cmd_start_o (cmd_start)
    );

    dcache_ways #(
        .NUM_SETS (NUM_SETS)
    ) u_ways (
        .clk        (clk),
        .rst_i      (rst_i),
        .rd_index_i (rd_index),
        .wr_i       (way_wr),
        .line0_o    (line0),
        .line1_o    (line1)
    );

    dcache_mem_port u_mem_port (
        .clk         (clk),
        .rst_i       (rst_i),
        .cmd_i       (cmd),
        .cmd_start_i (cmd_start),
        .mem_ready_i (mem_ready_i),
        .mem_rdata_i (mem_rdata_i),
        .mem_req_o   (mem_req_o),
        .mem_valid_o (mem_valid_o),
        .cmd_done_o  (cmd_done),
        .fill_data_o (fill_data)
    );

endmodule

//--- test/tb_mem_model.sv
// behavioral main memory with random ready delay and a log of served requests
`timescale 1ns/100ps

module tb_mem_model
    import dcache_pkg::*;
#(
    parameter logic [63:0] FILL_KEY = '0
) (
    input  logic     clk,
    input  logic     rst_i,
    input  mem_cmd_t mem_req_i,
    input  logic     mem_valid_i,
    output logic     mem_ready_o,
    output word_t    mem_rdata_o
);

    word_t      store    [addr_t];
    mem_cmd_t   served_q [$];
    int         wb_count = 0;
    int         refill_count = 0;
    logic [7:0] lfsr_q = 8'd82;

    // taps 8,6,5,4, maximal length
    function automatic logic [7:0] lfsr_step(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    // untouched words hold their word address xor the key
    function automatic word_t read_word(input addr_t a);
        return store.exists(a) ? store[a] : ((a >> OFFSET_W) ^ FILL_KEY);
    endfunction

    initial begin
        logic [2:0] delay;
        mem_ready_o = 1'b0;
        mem_rdata_o = '0;
        forever begin
            @(posedge clk);
            #1;
            mem_ready_o = 1'b0;
            if (!rst_i && mem_valid_i) begin
                delay = '0;
                for (int i = 0; i < 3; i++) begin
                    delay  = {delay[1:0], lfsr_q[7]};
                    lfsr_q = lfsr_step(lfsr_q);
                end
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                served_q.push_back(mem_req_i);
                if (mem_req_i.kind == MEM_WRITEBACK) begin
                    store[mem_req_i.addr] = mem_req_i.data;
                    wb_count++;
                end else begin
                    mem_rdata_o = read_word(mem_req_i.addr);
                    refill_count++;
                end
                // one ready cycle, dropped after the next edge
                mem_ready_o = 1'b1;
            end
        end
    end

endmodule

//--- test/tb_dcache.sv
// data cache testbench with clock, reset, reference model, assertions, timeout and reporting
`timescale 1ns/100ps

module tb_dcache
    import dcache_pkg::*;
();

    localparam int          SETS     = 2 ** INDEX_W;
    localparam logic [63:0] FILL_KEY = 64'h5a3c_96e1_0f87_d2b4;
    // 11 requests at up to 26 cycles for a dirty miss with the longest delays, wide margin
    localparam int          CYCLE_LIMIT = 4000;
    localparam index_t      SET_A = 6'd5;
    localparam tag_t        T1 = 55'h100;
    localparam tag_t        T2 = 55'h200;
    localparam tag_t        T3 = 55'h300;
    localparam tag_t        T4 = 55'h400;

    logic     clk;
    logic     rst_i;
    logic     rd_valid_i;
    logic     wr_valid_i;
    addr_t    addr_i;
    word_t    wdata_i;
    strb_t    strb_i;
    logic     mem_ready_i;
    word_t    mem_rdata_i;
    logic     done_o;
    word_t    rdata_o;
    mem_cmd_t mem_req_o;
    logic     mem_valid_o;

    int errors = 0;
    int cycles = 0;
    int tests_run = 0;
    int tests_bad = 0;
    int err_mark = 0;
    int wb_mark;

    // reference model state per set and way
    logic             r_valid [SETS][2];
    tag_t             r_tag   [SETS][2];
    word_t            r_data  [SETS][2];
    logic             r_dirty [SETS][2];
    logic [AGE_W-1:0] r_age   [SETS][2];
    word_t            r_mem   [addr_t];
    mem_cmd_t         exp_q   [$];

    dcache_top #(.NUM_SETS(SETS)) uut (
        .clk(clk), .rst_i(rst_i), .rd_valid_i(rd_valid_i), .wr_valid_i(wr_valid_i),
        .addr_i(addr_i), .wdata_i(wdata_i), .strb_i(strb_i), .mem_ready_i(mem_ready_i),
        .mem_rdata_i(mem_rdata_i), .done_o(done_o), .rdata_o(rdata_o),
        .mem_req_o(mem_req_o), .mem_valid_o(mem_valid_o)
    );

    tb_mem_model #(.FILL_KEY(FILL_KEY)) u_mem (
        .clk(clk), .rst_i(rst_i), .mem_req_i(mem_req_o), .mem_valid_i(mem_valid_o),
        .mem_ready_o(mem_ready_i), .mem_rdata_o(mem_rdata_i)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("SOME TESTS FAILED");
            $finish;
        end
    end

    function automatic void flag_error(input string msg);
        errors++;
        $display("FAILED at %0d ns: %s", $time, msg);
    endfunction

    a_reset_quiet: assert property (@(posedge clk) rst_i |=> (!done_o && !mem_valid_o))
        else flag_error("done_o or mem_valid_o high after a reset cycle");
    a_done_pulse: assert property (@(posedge clk) disable iff (rst_i) done_o |=> !done_o)
        else flag_error("done_o high for more than one cycle");
    a_req_hold: assert property (@(posedge clk) disable iff (rst_i)
        (mem_valid_o && !mem_ready_i) |=> (mem_valid_o && $stable(mem_req_o)))
        else flag_error("memory request changed before mem_ready_i");

    function automatic addr_t line_addr(input tag_t tg, input index_t idx);
        return {tg, idx, 3'b000};
    endfunction

    function automatic word_t mem_word(input addr_t a);
        return r_mem.exists(a) ? r_mem[a] : ((a >> OFFSET_W) ^ FILL_KEY);
    endfunction

    function automatic logic [AGE_W-1:0] aged(input logic [AGE_W-1:0] a);
        return (a == '1) ? a : a + 1'b1;
    endfunction

    // expected data, hit and memory commands of one request
    task automatic model_access(input logic wr, input addr_t addr, input word_t wdata,
                                input strb_t strb, output word_t rdata, output logic hit);
        index_t   idx;
        tag_t     tg;
        way_t     w;
        mem_cmd_t c;
        idx = addr[OFFSET_W +: INDEX_W];
        tg  = addr[OFFSET_W+INDEX_W +: TAG_W];
        hit = 1'b0;
        w   = 1'b0;
        for (int i = 0; i < 2; i++) begin
            if (r_valid[idx][i] && r_tag[idx][i] == tg) begin
                hit = 1'b1;
                w   = way_t'(i);
            end
        end
        if (!hit) begin
            if (!r_valid[idx][0])
                w = 1'b0;
            else if (!r_valid[idx][1])
                w = 1'b1;
            else
                w = r_age[idx][1] > r_age[idx][0];
            if (r_valid[idx][w] && r_dirty[idx][w]) begin
                c = '{MEM_WRITEBACK, line_addr(r_tag[idx][w], idx), r_data[idx][w]};
                exp_q.push_back(c);
                r_mem[c.addr] = c.data;
            end
            c = '{MEM_REFILL, line_addr(tg, idx), '0};
            exp_q.push_back(c);
            r_valid[idx][w] = 1'b1;
            r_tag[idx][w]   = tg;
            r_data[idx][w]  = mem_word(c.addr);
            r_dirty[idx][w] = 1'b0;
        end
        // the access then hits in way w
        r_age[idx][w]  = '0;
        r_age[idx][!w] = aged(r_age[idx][!w]);
        if (wr) begin
            for (int b = 0; b < STRB_W; b++) begin
                if (strb[b]) begin
                    r_data[idx][w][b*8 +: 8] = wdata[b*8 +: 8];
                end
            end
            r_dirty[idx][w] = 1'b1;
        end
        rdata = r_data[idx][w];
    endtask

    // edges counts from the edge that samples the valid to the one that samples done_o
    task automatic drive_request(input logic wr, input addr_t addr, input word_t wdata,
                                 input strb_t strb, output word_t rdata, output int edges);
        rd_valid_i = !wr;
        wr_valid_i = wr;
        addr_i     = addr;
        wdata_i    = wdata;
        strb_i     = strb;
        edges      = 0;
        do begin
            @(posedge clk);
            #1;
            edges++;
        end while (!done_o);
        rdata = rdata_o;
        @(posedge clk);
        #1;
        edges++;
        rd_valid_i = 1'b0;
        wr_valid_i = 1'b0;
    endtask

    task automatic check_request(input logic wr, input addr_t addr, input word_t wdata,
                                 input strb_t strb);
        word_t exp_data;
        logic  exp_hit;
        word_t got;
        int    edges;
        int    base;
        exp_q.delete();
        base = u_mem.served_q.size();
        model_access(wr, addr, wdata, strb, exp_data, exp_hit);
        drive_request(wr, addr, wdata, strb, got, edges);
        assert (u_mem.served_q.size() - base == exp_q.size())
            else flag_error($sformatf("%0d memory requests for %h, expected %0d",
                                      u_mem.served_q.size() - base, addr, exp_q.size()));
        foreach (exp_q[i]) begin
            if (base + i < u_mem.served_q.size()) begin
                assert (u_mem.served_q[base + i] == exp_q[i])
                    else flag_error($sformatf("memory request %h, expected %h",
                                              u_mem.served_q[base + i], exp_q[i]));
            end
        end
        if (!wr) begin
            assert (got == exp_data)
                else flag_error($sformatf("read %h gave %h, expected %h", addr, got, exp_data));
        end
        if (exp_hit) begin
            assert (edges == 3)
                else flag_error($sformatf("hit on %h took %0d edges, expected 3", addr, edges));
        end
    endtask

    task automatic end_test(input string name);
        tests_run++;
        if (errors == err_mark) begin
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            tests_bad++;
            $display("test %0d %s: %0d errors", tests_run, name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        rst_i      = 1'b1;
        rd_valid_i = 1'b0;
        wr_valid_i = 1'b0;
        addr_i     = '0;
        wdata_i    = '0;
        strb_i     = '0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < 2; w++) begin
                r_valid[s][w] = 1'b0;
                r_dirty[s][w] = 1'b0;
                r_age[s][w]   = '0;
            end
        end

        repeat (12) begin
            @(posedge clk);
            #1;
            if (cycles >= 8) begin
                rst_i = 1'b0;
            end
            assert (!done_o && !mem_valid_o)
                else flag_error("done_o or mem_valid_o high around reset");
        end
        end_test("reset");

        // cold read with a byte offset refills the aligned address
        check_request(1'b0, line_addr(T1, SET_A) + 64'd5, '0, '0);
        assert (u_mem.refill_count == 1 && u_mem.wb_count == 0)
            else flag_error("cold read did not cause exactly one refill");
        end_test("read miss and refill");

        check_request(1'b0, line_addr(T1, SET_A), '0, '0);
        end_test("read hit");

        check_request(1'b1, line_addr(T1, SET_A), 64'h1122_3344_5566_7788, 8'b0011_0100);
        check_request(1'b0, line_addr(T1, SET_A), '0, '0);
        end_test("strobed write hit");

        // T3 evicts T2 since T1 was touched again before it
        check_request(1'b0, line_addr(T2, SET_A), '0, '0);
        check_request(1'b0, line_addr(T1, SET_A), '0, '0);
        check_request(1'b0, line_addr(T3, SET_A), '0, '0);
        check_request(1'b0, line_addr(T1, SET_A), '0, '0);
        check_request(1'b0, line_addr(T2, SET_A), '0, '0);
        end_test("replacement");

        wb_mark = u_mem.wb_count;
        check_request(1'b0, line_addr(T4, SET_A), '0, '0);
        assert (u_mem.wb_count == wb_mark + 1)
            else flag_error("evicting the dirty line issued no write-back");
        check_request(1'b0, line_addr(T1, SET_A), '0, '0);
        end_test("dirty write-back");

        $display("%0d tests run, %0d with errors, %0d failed checks",
                 tests_run, tests_bad, errors);
        if (errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

//--- all.f
rtl/dcache_pkg.sv
rtl/dcache_ways.sv
rtl/dcache_ctrl.sv
rtl/dcache_mem_port.sv
rtl/dcache_top.sv
test/tb_mem_model.sv
test/tb_dcache.sv

//--- run.sh
#!/bin/sh
# compile and run the data cache testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f all.f --top-module tb_dcache

out=$(./obj_dir/Vtb_dcache)
echo "$out"

# the run passes only if the pass line was printed
echo "$out" | grep -q "ALL TESTS PASSED"
